//--- build.f
+incdir+tb
source/isa_pkg.sv
source/uop_pkg.sv
source/insn_decoder.sv
source/insn_fifo.sv
source/uop_expander.sv
source/x86_front.sv
tb/tb_x86_front.sv

//--- source/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
  input  logic                clk,
  input  logic                rstn,
  input  logic                flush,
  input  isa_pkg::byte_t      byte_in,
  input  logic                byte_valid,
  input  logic                fifo_full,
  output logic                dec_valid,
  output uop_pkg::insn_kind_t dec_kind,
  output uop_pkg::miop_t      dec_op,
  output isa_pkg::rega_t      dec_reg,
  output isa_pkg::imm_t       dec_imm,
  output isa_pkg::bmd_t       dec_bmd
);
  import isa_pkg::*;
  import uop_pkg::*;

  typedef enum logic {
    S_OPCODE,
    S_IMMEDIATE   // Also collects rel8 displacements
  } dec_state_t;

  dec_state_t state;
  logic       rex_w;
  logic       rex_b;
  logic [2:0] imm_bytes;   // 1 or 4
  logic [1:0] byte_cnt;

  logic       take;
  logic       is_rex;
  logic       op_known;
  insn_kind_t op_kind;
  miop_t      op_code;
  rega_t      op_reg;
  bmd_t       op_bmd;
  logic [2:0] op_len;
  bmd_t       wide_bmd;

  assign take     = byte_valid && !fifo_full;
  assign is_rex   = byte_in[7:4] == OP_REX_BASE[7:4];
  assign wide_bmd = rex_w ? BMD_64 : BMD_32;

  // Opcode classification, op_len of 0 means no trailing bytes
  always_comb
  begin
    op_known = 1'b1;
    op_kind  = K_ALU_IMM;
    op_code  = NOP;
    op_reg   = '0;
    op_bmd   = BMD_32;
    op_len   = 3'd0;
    if (byte_in[7:6] == 2'b00 && byte_in[2:1] == 2'b10)
    begin
      op_code = miop_t'(ADDI + byte_in[5:3]);   // x86 ALU order
      op_reg  = RAX_ADDR;
      op_bmd  = byte_in[0] ? wide_bmd : BMD_08;
      op_len  = byte_in[0] ? 3'd4 : 3'd1;
    end
    else if (byte_in[7:4] == OP_MOVI_BASE[7:4])
    begin
      op_kind = K_MOV_IMM;
      op_code = MOVI;
      op_reg  = rega_t'({rex_b, byte_in[2:0]});
      op_bmd  = byte_in[3] ? wide_bmd : BMD_08;
      op_len  = byte_in[3] ? 3'd4 : 3'd1;
    end
    else if (byte_in[7:4] == OP_PUSH_BASE[7:4])
    begin
      op_kind = byte_in[3] ? K_POP : K_PUSH;
      op_code = byte_in[3] ? L : S;
      op_reg  = rega_t'({rex_b, byte_in[2:0]});
      op_bmd  = BMD_64;
    end
    else if (byte_in[7:4] == OP_JCC_BASE[7:4])
    begin
      op_kind = K_JCC;
      op_code = miop_t'(JO + byte_in[3:0]);
      op_len  = 3'd1;
    end
    else if (byte_in == OP_JMP_REL8)
    begin
      op_kind = K_JMP;
      op_code = J;
      op_len  = 3'd1;
    end
    else if (byte_in == OP_RET)
    begin
      op_kind = K_RET;
      op_code = JR;
      op_bmd  = BMD_64;
    end
    else
    begin
      op_known = 1'b0;   // Consumed silently
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstn || flush)
    begin
      state     <= S_OPCODE;
      rex_w     <= 1'b0;
      rex_b     <= 1'b0;
      byte_cnt  <= '0;
      dec_valid <= 1'b0;
    end
    else
    begin
      dec_valid <= 1'b0;
      if (take)
      begin
        case (state)
          S_OPCODE:
          begin
            rex_w    <= is_rex && byte_in[3];   // REX lives for one opcode only
            rex_b    <= is_rex && byte_in[0];
            byte_cnt <= '0;
            if (!is_rex && op_known)
            begin
              if (op_len == 3'd0)
                dec_valid <= 1'b1;
              else
                state <= S_IMMEDIATE;
            end
          end
          default:
          begin
            byte_cnt <= byte_cnt + 2'd1;
            if (3'(byte_cnt) + 3'd1 == imm_bytes)
            begin
              state     <= S_OPCODE;
              dec_valid <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  // Little-endian assembly, each new byte re-extends the sign
  always_ff @(posedge clk)
  begin
    if (take && state == S_OPCODE)
    begin
      dec_kind  <= op_kind;
      dec_op    <= op_code;
      dec_reg   <= op_reg;
      dec_bmd   <= op_bmd;
      dec_imm   <= '0;
      imm_bytes <= op_len;
    end
    else if (take)
    begin
      case (byte_cnt)
        2'd0:    dec_imm              <= imm_t'(signed'(byte_in));
        2'd1:    dec_imm[IMM_W-1:8]   <= (IMM_W-8)'(signed'(byte_in));
        2'd2:    dec_imm[IMM_W-1:16]  <= (IMM_W-16)'(signed'(byte_in));
        default: dec_imm[IMM_W-1:24]  <= (IMM_W-24)'(signed'(byte_in));
      endcase
    end
  end

endmodule

//--- source/insn_fifo.sv
`timescale 1ns/1ps

module insn_fifo #(
  parameter int DEPTH = uop_pkg::FIFO_DEPTH
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                flush,
  input  logic                wr,
  input  uop_pkg::insn_kind_t dec_kind,
  input  uop_pkg::miop_t      dec_op,
  input  isa_pkg::rega_t      dec_reg,
  input  isa_pkg::imm_t       dec_imm,
  input  isa_pkg::bmd_t       dec_bmd,
  input  logic                rd,
  output uop_pkg::insn_kind_t q_kind,
  output uop_pkg::miop_t      q_op,
  output isa_pkg::rega_t      q_reg,
  output isa_pkg::imm_t       q_imm,
  output isa_pkg::bmd_t       q_bmd,
  output logic                empty,
  output logic                full
);
  import isa_pkg::*;
  import uop_pkg::*;

  insn_kind_t kind_mem [DEPTH];
  miop_t      op_mem   [DEPTH];
  rega_t      reg_mem  [DEPTH];
  imm_t       imm_mem  [DEPTH];
  bmd_t       bmd_mem  [DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] p);
    return (p == FIFO_PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr = wr && (count != (FIFO_PTR_W+1)'(DEPTH));
  assign do_rd = rd && !empty;
  assign empty = count == '0;
  // Counts a write in flight, so the decoder stops before the last slot is taken
  assign full  = (count == (FIFO_PTR_W+1)'(DEPTH)) ||
                 (wr && count == (FIFO_PTR_W+1)'(DEPTH - 1));

  assign q_kind = kind_mem[rd_ptr];
  assign q_op   = op_mem[rd_ptr];
  assign q_reg  = reg_mem[rd_ptr];
  assign q_imm  = imm_mem[rd_ptr];
  assign q_bmd  = bmd_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      kind_mem[wr_ptr] <= dec_kind;
      op_mem[wr_ptr]   <= dec_op;
      reg_mem[wr_ptr]  <= dec_reg;
      imm_mem[wr_ptr]  <= dec_imm;
      bmd_mem[wr_ptr]  <= dec_bmd;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstn || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Idle or read with write
      endcase
    end
  end

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 32;

  typedef logic [7:0]            byte_t;
  typedef logic [REG_ADDR_W-1:0] rega_t;   // Micro-architectural register number
  typedef logic [IMM_W-1:0]      imm_t;    // Sign-extended immediate or displacement

  typedef enum logic [1:0] {
    BMD_08,
    BMD_32,
    BMD_64
  } bmd_t;

  localparam rega_t RAX_ADDR = 5'd0;
  localparam rega_t RSP_ADDR = 5'd4;
  localparam rega_t TMP_ADDR = 5'd16;   // Scratch, outside the x86 register file

  // One-byte opcodes, low nibble selects register or condition
  localparam byte_t OP_REX_BASE  = 8'h40;
  localparam byte_t OP_PUSH_BASE = 8'h50;   // 58-5F are the POP forms
  localparam byte_t OP_JCC_BASE  = 8'h70;
  localparam byte_t OP_MOVI_BASE = 8'hB0;   // B8-BF take a 32-bit immediate
  localparam byte_t OP_RET       = 8'hC3;
  localparam byte_t OP_JMP_REL8  = 8'hEB;

  localparam imm_t STACK_STEP = 32'd8;

endpackage

//--- source/uop_expander.sv
`timescale 1ns/1ps

module uop_expander (
  input  logic                clk,
  input  logic                rstn,
  input  logic                flush,
  input  logic                stall,
  input  uop_pkg::insn_kind_t q_kind,
  input  uop_pkg::miop_t      q_op,
  input  isa_pkg::rega_t      q_reg,
  input  isa_pkg::imm_t       q_imm,
  input  isa_pkg::bmd_t       q_bmd,
  input  logic                q_empty,
  output logic                q_pop,
  output logic                uop_valid,
  output uop_pkg::miop_t      uop_op,
  output isa_pkg::rega_t      uop_d,
  output isa_pkg::rega_t      uop_s,
  output isa_pkg::rega_t      uop_t,
  output isa_pkg::imm_t       uop_imm,
  output isa_pkg::bmd_t       uop_bmd,
  output logic                uop_last
);
  import isa_pkg::*;
  import uop_pkg::*;

  logic       busy;
  logic [1:0] step;   // Index of the next micro-op in the entry
  insn_kind_t cur_kind;
  miop_t      cur_op;
  rega_t      cur_reg;
  imm_t       cur_imm;
  bmd_t       cur_bmd;

  assign uop_valid = busy && !stall;
  // Next entry is taken on the same edge as the final micro-op
  assign q_pop     = !flush && !q_empty && (!busy || (uop_valid && uop_last));

  always_ff @(posedge clk)
  begin
    if (!rstn || flush)
    begin
      busy <= 1'b0;
      step <= '0;
    end
    else
    begin
      if (uop_valid)
      begin
        step <= uop_last ? 2'd0 : step + 2'd1;
        if (uop_last)
          busy <= 1'b0;
      end
      if (q_pop)
      begin
        busy <= 1'b1;
        step <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (q_pop)
    begin
      cur_kind <= q_kind;
      cur_op   <= q_op;
      cur_reg  <= q_reg;
      cur_imm  <= q_imm;
      cur_bmd  <= q_bmd;
    end
  end

  always_comb
  begin
    uop_op   = NOP;
    uop_d    = '0;
    uop_s    = '0;
    uop_t    = '0;   // No three-register forms in this subset
    uop_imm  = '0;
    uop_bmd  = cur_bmd;
    uop_last = 1'b1;
    case (cur_kind)
      K_ALU_IMM:
      begin
        uop_op  = cur_op;
        uop_d   = RAX_ADDR;
        uop_s   = RAX_ADDR;
        uop_imm = cur_imm;
      end
      K_MOV_IMM:
      begin
        uop_op  = MOVI;
        uop_d   = cur_reg;
        uop_imm = cur_imm;
      end
      K_PUSH:
      begin
        uop_bmd  = BMD_64;
        uop_last = step == 2'd1;
        if (step == 2'd0)
        begin
          uop_op  = ADDI;   // Pre-decrement RSP
          uop_d   = RSP_ADDR;
          uop_s   = RSP_ADDR;
          uop_imm = -STACK_STEP;
        end
        else
        begin
          uop_op = S;
          uop_d  = cur_reg;
          uop_s  = RSP_ADDR;
        end
      end
      K_POP, K_RET:
      begin
        uop_bmd  = BMD_64;
        uop_last = (cur_kind == K_POP) ? step == 2'd1 : step == 2'd2;
        if (step == 2'd0)
        begin
          uop_op = L;
          uop_d  = (cur_kind == K_POP) ? cur_reg : TMP_ADDR;
          uop_s  = RSP_ADDR;
        end
        else if (step == 2'd1)
        begin
          uop_op  = ADDI;
          uop_d   = RSP_ADDR;
          uop_s   = RSP_ADDR;
          uop_imm = STACK_STEP;
        end
        else
        begin
          uop_op  = JR;   // Return through the popped address
          uop_d   = TMP_ADDR;
          uop_bmd = BMD_32;
        end
      end
      K_JCC:
      begin
        uop_op  = cur_op;
        uop_imm = cur_imm;
      end
      default:
      begin
        uop_op  = J;
        uop_imm = cur_imm;
        uop_bmd = BMD_32;
      end
    endcase
  end

endmodule

//--- source/uop_pkg.sv
package uop_pkg;

  // Jcc codes follow the x86 condition nibble, ALU codes follow opcode bits 5:3
  typedef enum logic [5:0] {
    NOP,
    ADDI, ORI, ADCI, SBBI, ANDI, SUBI, XORI, CMPI,
    MOVI,
    L,
    S,
    J,
    JR,
    JO, JNO, JB, JAE, JE, JNE, JBE, JA,
    JS, JNS, JP, JNP, JL, JGE, JLE, JG
  } miop_t;

  typedef enum logic [2:0] {
    K_ALU_IMM,
    K_MOV_IMM,
    K_PUSH,
    K_POP,
    K_JCC,
    K_JMP,
    K_RET
  } insn_kind_t;

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;

endpackage

//--- source/x86_front.sv
`timescale 1ns/1ps

module x86_front (
  input  logic           clk,
  input  logic           rstn,
  input  isa_pkg::byte_t byte_in,
  input  logic           byte_valid,
  input  logic           stall,
  input  logic           flush,
  output logic           fetch_hold,
  output logic           uop_valid,
  output uop_pkg::miop_t uop_op,
  output isa_pkg::rega_t uop_d,
  output isa_pkg::rega_t uop_s,
  output isa_pkg::rega_t uop_t,
  output isa_pkg::imm_t  uop_imm,
  output isa_pkg::bmd_t  uop_bmd,
  output logic           uop_last
);
  import isa_pkg::*;
  import uop_pkg::*;

  logic       dec_valid;
  insn_kind_t dec_kind;
  miop_t      dec_op;
  rega_t      dec_reg;
  imm_t       dec_imm;
  bmd_t       dec_bmd;
  logic       fifo_full;

  insn_kind_t q_kind;
  miop_t      q_op;
  rega_t      q_reg;
  imm_t       q_imm;
  bmd_t       q_bmd;
  logic       q_empty;
  logic       q_pop;

  assign fetch_hold = fifo_full;   // Only back-pressure toward the byte source

  insn_decoder u_dec (
    .clk(clk), .rstn(rstn), .flush(flush),
    .byte_in(byte_in), .byte_valid(byte_valid), .fifo_full(fifo_full),
    .dec_valid(dec_valid), .dec_kind(dec_kind), .dec_op(dec_op),
    .dec_reg(dec_reg), .dec_imm(dec_imm), .dec_bmd(dec_bmd)
  );

  insn_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .rstn(rstn), .flush(flush), .wr(dec_valid),
    .dec_kind(dec_kind), .dec_op(dec_op), .dec_reg(dec_reg),
    .dec_imm(dec_imm), .dec_bmd(dec_bmd), .rd(q_pop),
    .q_kind(q_kind), .q_op(q_op), .q_reg(q_reg), .q_imm(q_imm), .q_bmd(q_bmd),
    .empty(q_empty), .full(fifo_full)
  );

  uop_expander u_exp (
    .clk(clk), .rstn(rstn), .flush(flush), .stall(stall),
    .q_kind(q_kind), .q_op(q_op), .q_reg(q_reg), .q_imm(q_imm), .q_bmd(q_bmd),
    .q_empty(q_empty), .q_pop(q_pop), .uop_valid(uop_valid),
    .uop_op(uop_op), .uop_d(uop_d), .uop_s(uop_s), .uop_t(uop_t),
    .uop_imm(uop_imm), .uop_bmd(uop_bmd), .uop_last(uop_last)
  );

endmodule

//--- tb/insn_table.svh
add_row("add8", 48'h04_80, 2, ADDI, 0, 0, 0, 32'hFFFF_FF80, BMD_08);   // name, bytes, count, uop
add_row("or8", 48'h0C_9C, 2, ORI, 0, 0, 0, 32'hFFFF_FF9C, BMD_08);
add_row("adc8", 48'h14_F0, 2, ADCI, 0, 0, 0, 32'hFFFF_FFF0, BMD_08);
add_row("sbb8", 48'h1C_FF, 2, SBBI, 0, 0, 0, 32'hFFFF_FFFF, BMD_08);
add_row("and8", 48'h24_C3, 2, ANDI, 0, 0, 0, 32'hFFFF_FFC3, BMD_08);
add_row("sub8", 48'h2C_81, 2, SUBI, 0, 0, 0, 32'hFFFF_FF81, BMD_08);
add_row("xor8", 48'h34_A5, 2, XORI, 0, 0, 0, 32'hFFFF_FFA5, BMD_08);
add_row("cmp8", 48'h3C_FE, 2, CMPI, 0, 0, 0, 32'hFFFF_FFFE, BMD_08);
add_row("add64", 48'h48_05_78_56_34_92, 6, ADDI, 0, 0, 0, 32'h9234_5678, BMD_64);
add_row("or64", 48'h48_0D_01_02_03_04, 6, ORI, 0, 0, 0, 32'h0403_0201, BMD_64);
add_row("adc64", 48'h48_15_FF_FF_FF_FF, 6, ADCI, 0, 0, 0, 32'hFFFF_FFFF, BMD_64);
add_row("sbb64", 48'h48_1D_00_00_00_80, 6, SBBI, 0, 0, 0, 32'h8000_0000, BMD_64);
add_row("and64", 48'h48_25_F0_0F_00_00, 6, ANDI, 0, 0, 0, 32'h0000_0FF0, BMD_64);
add_row("sub64", 48'h48_2D_10_32_54_76, 6, SUBI, 0, 0, 0, 32'h7654_3210, BMD_64);
add_row("xor64", 48'h48_35_EF_BE_AD_DE, 6, XORI, 0, 0, 0, 32'hDEAD_BEEF, BMD_64);
add_row("cmp64", 48'h48_3D_7F_00_00_00, 6, CMPI, 0, 0, 0, 32'h0000_007F, BMD_64);
add_row("mov8 r0", 48'hB0_7F, 2, MOVI, 0, 0, 0, 32'h0000_007F, BMD_08);
add_row("mov8 r3", 48'hB3_FE, 2, MOVI, 3, 0, 0, 32'hFFFF_FFFE, BMD_08);
add_row("mov8 r12", 48'h41_B4_81, 3, MOVI, 12, 0, 0, 32'hFFFF_FF81, BMD_08);
add_row("mov32 r9", 48'h41_B9_44_33_22_11, 6, MOVI, 9, 0, 0, 32'h1122_3344, BMD_32);
add_row("mov64 r15", 48'h49_BF_01_00_00_80, 6, MOVI, 15, 0, 0, 32'h8000_0001, BMD_64);
add_row("push rbx", 48'h53, 1, ADDI, 4, 4, 0, 32'hFFFF_FFF8, BMD_64);
add_uop(S, 3, 4, 0, 32'h0, BMD_64);
add_row("pop r12", 48'h41_5C, 2, L, 12, 4, 0, 32'h0, BMD_64);
add_uop(ADDI, 4, 4, 0, 32'h8, BMD_64);
add_row("push r15", 48'h41_57, 2, ADDI, 4, 4, 0, 32'hFFFF_FFF8, BMD_64);
add_uop(S, 15, 4, 0, 32'h0, BMD_64);
add_row("pop rax", 48'h58, 1, L, 0, 4, 0, 32'h0, BMD_64);
add_uop(ADDI, 4, 4, 0, 32'h8, BMD_64);
add_row("jo", 48'h70_05, 2, JO, 0, 0, 0, 32'h0000_0005, BMD_32);
add_row("jno", 48'h71_FB, 2, JNO, 0, 0, 0, 32'hFFFF_FFFB, BMD_32);
add_row("jb", 48'h72_10, 2, JB, 0, 0, 0, 32'h0000_0010, BMD_32);
add_row("jae", 48'h73_80, 2, JAE, 0, 0, 0, 32'hFFFF_FF80, BMD_32);
add_row("je", 48'h74_7F, 2, JE, 0, 0, 0, 32'h0000_007F, BMD_32);
add_row("jne", 48'h75_F0, 2, JNE, 0, 0, 0, 32'hFFFF_FFF0, BMD_32);
add_row("jbe", 48'h76_02, 2, JBE, 0, 0, 0, 32'h0000_0002, BMD_32);
add_row("ja", 48'h77_FE, 2, JA, 0, 0, 0, 32'hFFFF_FFFE, BMD_32);
add_row("js", 48'h78_20, 2, JS, 0, 0, 0, 32'h0000_0020, BMD_32);
add_row("jns", 48'h79_E0, 2, JNS, 0, 0, 0, 32'hFFFF_FFE0, BMD_32);
add_row("jp", 48'h7A_01, 2, JP, 0, 0, 0, 32'h0000_0001, BMD_32);
add_row("jnp", 48'h7B_FF, 2, JNP, 0, 0, 0, 32'hFFFF_FFFF, BMD_32);
add_row("jl", 48'h7C_40, 2, JL, 0, 0, 0, 32'h0000_0040, BMD_32);
add_row("jge", 48'h7D_C0, 2, JGE, 0, 0, 0, 32'hFFFF_FFC0, BMD_32);
add_row("jle", 48'h7E_33, 2, JLE, 0, 0, 0, 32'h0000_0033, BMD_32);
add_row("jg", 48'h7F_9A, 2, JG, 0, 0, 0, 32'hFFFF_FF9A, BMD_32);
add_row("jmp back", 48'hEB_80, 2, J, 0, 0, 0, 32'hFFFF_FF80, BMD_32);
add_row("jmp fwd", 48'hEB_0C, 2, J, 0, 0, 0, 32'h0000_000C, BMD_32);
add_row("ret", 48'hC3, 1, L, 16, 4, 0, 32'h0, BMD_64);
add_uop(ADDI, 4, 4, 0, 32'h8, BMD_64);
add_uop(JR, 16, 0, 0, 32'h0, BMD_32);
skip_row("unsupported", 48'h0F_90_06, 3);
skip_row("rex unsupported", 48'h48_90, 2);
add_row("mixed add", 48'h06_90_04_05, 4, ADDI, 0, 0, 0, 32'h0000_0005, BMD_08);
add_row("flush mov", 48'hB8_11_22_33_44, 5, MOVI, 0, 0, 0, 32'h4433_2211, BMD_32);
flush_after(3);
add_row("mov after flush", 48'hBA_EF_BE_AD_DE, 5, MOVI, 2, 0, 0, 32'hDEAD_BEEF, BMD_32);
add_row("flush or64", 48'h48_0D_11_22_33_44, 6, ORI, 0, 0, 0, 32'h4433_2211, BMD_64);
flush_after(3);
add_row("or after flush", 48'h0D_01_00_00_00, 5, ORI, 0, 0, 0, 32'h0000_0001, BMD_32);
add_row("ret tail", 48'hC3, 1, L, 16, 4, 0, 32'h0, BMD_64);
add_uop(ADDI, 4, 4, 0, 32'h8, BMD_64);
add_uop(JR, 16, 0, 0, 32'h0, BMD_32);

//--- tb/tb_x86_front.sv
`timescale 1ns/1ps

module tb_x86_front;
  import isa_pkg::*;
  import uop_pkg::*;

  localparam int MAX_ROWS = 64;
  localparam int MAX_UOPS = 96;

  logic  clk;
  logic  rstn;
  byte_t byte_in;
  logic  byte_valid;
  logic  stall;
  logic  flush;
  logic  fetch_hold;
  logic  uop_valid;
  miop_t uop_op;
  rega_t uop_d;
  rega_t uop_s;
  rega_t uop_t;
  imm_t  uop_imm;
  bmd_t  uop_bmd;
  logic  uop_last;

  string       row_name  [MAX_ROWS];
  logic [47:0] row_bytes [MAX_ROWS];   // First byte in the top used byte
  int          row_len   [MAX_ROWS];
  int          row_flush [MAX_ROWS];   // Bytes sent before the flush, 0 for none
  int          row_first [MAX_ROWS];
  int          row_nuops [MAX_ROWS];
  miop_t       u_op  [MAX_UOPS];
  rega_t       u_d   [MAX_UOPS];
  rega_t       u_s   [MAX_UOPS];
  rega_t       u_t   [MAX_UOPS];
  imm_t        u_imm [MAX_UOPS];
  bmd_t        u_bmd [MAX_UOPS];
  int          u_row [MAX_UOPS];
  int          n_rows = 0;
  int          n_uops = 0;
  int          exp_q[$];   // Indices of micro-ops still to come
  int          cycles = 0;
  int          mon_idx;
  logic        exp_last;
  int unsigned seed;

  x86_front dut0 (
    .clk(clk), .rstn(rstn), .byte_in(byte_in), .byte_valid(byte_valid),
    .stall(stall), .flush(flush), .fetch_hold(fetch_hold),
    .uop_valid(uop_valid), .uop_op(uop_op), .uop_d(uop_d), .uop_s(uop_s),
    .uop_t(uop_t), .uop_imm(uop_imm), .uop_bmd(uop_bmd), .uop_last(uop_last)
  );

  task automatic skip_row(input string name, input logic [47:0] b, input int n);
    row_name[n_rows]  = name;
    row_bytes[n_rows] = b;
    row_len[n_rows]   = n;
    row_flush[n_rows] = 0;
    row_first[n_rows] = n_uops;
    row_nuops[n_rows] = 0;
    n_rows++;
  endtask

  task automatic add_uop(input miop_t op, input rega_t dst, input rega_t src,
                         input rega_t src2, input imm_t imm, input bmd_t bmd);
    u_op[n_uops]  = op;
    u_d[n_uops]   = dst;
    u_s[n_uops]   = src;
    u_t[n_uops]   = src2;
    u_imm[n_uops] = imm;
    u_bmd[n_uops] = bmd;
    u_row[n_uops] = n_rows - 1;
    n_uops++;
    row_nuops[n_rows-1]++;
  endtask

  task automatic add_row(input string name, input logic [47:0] b, input int n,
                         input miop_t op, input rega_t dst, input rega_t src,
                         input rega_t src2, input imm_t imm, input bmd_t bmd);
    skip_row(name, b, n);
    add_uop(op, dst, src, src2, imm, bmd);
  endtask

  task automatic flush_after(input int k);
    row_flush[n_rows-1] = k;
  endtask

  task automatic load_table();
    `include "insn_table.svh"
  endtask

  function automatic byte_t row_byte(input int r, input int i);
    return row_bytes[r][8*(row_len[r]-1-i) +: 8];
  endfunction

  task automatic check(input string name, input string field,
                       input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s %s expected %0h actual %0h", name, field, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Holds the byte until an edge with fetch_hold low takes it
  task automatic send_byte(input byte_t b);
    logic held;
    byte_in    = b;
    byte_valid = 1'b1;
    do
    begin
      @(negedge clk);
      held = fetch_hold;
      @(posedge clk);
      #2;
    end while (held);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    seed  = $urandom(8194);
    stall = 1'b0;
    forever
    begin
      @(posedge clk);
      #2;
      stall = ($urandom % 100) < 45;   // Heavy enough to fill the queue
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > 30 * n_rows + 200)
    begin
      $display("Timeout after %0d cycles, micro-ops stopped arriving", cycles);
      $display("Simulation FAILED");
      $fatal(1, "Timeout");
    end
  end

  // Outputs settle after the drive point, sampled mid-cycle
  always @(negedge clk)
  begin
    if (rstn === 1'b1 && uop_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Micro-op %0h issued while none was expected", uop_op);
        $display("Simulation FAILED");
        $fatal(1, "Unexpected micro-op");
      end
      mon_idx  = exp_q.pop_front();
      exp_last = mon_idx == row_first[u_row[mon_idx]] + row_nuops[u_row[mon_idx]] - 1;
      check(row_name[u_row[mon_idx]], "op", u_op[mon_idx], uop_op);
      check(row_name[u_row[mon_idx]], "d", u_d[mon_idx], uop_d);
      check(row_name[u_row[mon_idx]], "s", u_s[mon_idx], uop_s);
      check(row_name[u_row[mon_idx]], "t", u_t[mon_idx], uop_t);
      check(row_name[u_row[mon_idx]], "imm", u_imm[mon_idx], uop_imm);
      check(row_name[u_row[mon_idx]], "bmd", u_bmd[mon_idx], uop_bmd);
      check(row_name[u_row[mon_idx]], "last", exp_last, uop_last);
    end
  end

  initial
  begin
    rstn       = 1'b0;
    byte_in    = '0;
    byte_valid = 1'b0;
    flush      = 1'b0;
    load_table();
    repeat (5) @(posedge clk);
    #2;
    rstn = 1'b1;
    check("reset", "fetch_hold", 1'b0, fetch_hold);
    check("reset", "uop_valid", 1'b0, uop_valid);
    for (int r = 0; r < n_rows; r++)
    begin
      if (row_flush[r] != 0)
      begin
        byte_valid = 1'b0;
        wait_drain();   // Flush must only hit the partial instruction
        for (int i = 0; i < row_flush[r]; i++)
          send_byte(row_byte(r, i));
        byte_valid = 1'b0;
        flush      = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
      end
      else
      begin
        for (int j = 0; j < row_nuops[r]; j++)
          exp_q.push_back(row_first[r] + j);
        for (int i = 0; i < row_len[r]; i++)
          send_byte(row_byte(r, i));
      end
    end
    byte_valid = 1'b0;
    wait_drain();
    repeat (10) @(posedge clk);   // Room for any stray micro-op
    check("idle", "fetch_hold", 1'b0, fetch_hold);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
